// ==== list.f ====
src/cdb_pkg.sv
src/complete_buffer.sv
src/phys_reg_file.sv
src/rob_status.sv
src/complete_stage.sv
sim/complete_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the complete stage testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1

log=sim.log
bin=complete_stage_sim

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f list.f --top-module complete_stage_tb -o "$bin"
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/"$bin" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^STATUS: PASS$" "$log"; then
  exit 0
fi
echo "pass line not found in $log"
exit 1

// ==== sim/complete_stage_tb.sv ====
// testbench for complete_stage: stimulus table, reference model, checks and watchdog
`timescale 1ns/1ps

module complete_stage_tb;
  import cdb_pkg::*;

  localparam int num_rows    = 6;
  localparam int cycle_limit = num_rows * 20 + num_pregs;  // rows plus the register sweep

  typedef struct packed {
    logic [3:0]             n_disp;      // entries dispatched before the results
    logic [num_fu-1:0][2:0] cnt;         // results per unit
    logic [num_fu-1:0][2:0] off;         // ROB offset of the unit's first result
    logic [tag_width-1:0]   tag_base;    // tag of offset 0, offset k uses base+k
    logic                   rb_en;
    logic [2:0]             rb_off;      // branch offset, rollback one cycle after accept
    logic [3:0]             exp_bcast;   // broadcasts the row should see
    logic [3:0]             exp_retire;  // retirements the row should see
  } test_row_t;

  logic                     clock;
  logic                     reset;
  logic [num_fu-1:0]        fu_done;
  fu_result_t [num_fu-1:0]  fu_result;
  logic [num_fu-1:0]        fu_ready;
  rollback_t                rollback;
  logic                     dispatch_en;
  logic [tag_width-1:0]     dispatch_tag;
  logic [rob_idx_width-1:0] dispatch_idx;
  logic                     rob_full;
  logic                     retire_valid;
  logic [tag_width-1:0]     retire_tag;
  logic [tag_width-1:0]     read_tag;
  logic [data_width-1:0]    read_value;
  cdb_t                     cdb;

  test_row_t             rows [num_rows];
  string                 row_name [num_rows];
  string                 cur_name;
  fu_result_t            pend [num_fu][8];    // results a unit still has to hand over
  int                    pend_rd [num_fu];
  int                    pend_wr [num_fu];
  ct_entry_t             mslot [num_fu];      // expected slot contents
  logic [data_width-1:0] exp_regs [num_pregs];
  bit                    comp_done [rob_depth];
  int                    rq_idx [$];          // live ROB entries, oldest first
  logic [tag_width-1:0]  rq_tag [$];
  int                    model_tail;
  int                    check_count;
  int                    error_count;
  int                    tests_failed;
  int                    bcast_count;
  int                    retire_count;
  int                    cycle_count;
  logic [31:0]           lcg_state = 32'h5615_7139;

  complete_stage uut (
    .clock        (clock),
    .reset        (reset),
    .fu_done      (fu_done),
    .fu_result    (fu_result),
    .fu_ready     (fu_ready),
    .rollback     (rollback),
    .dispatch_en  (dispatch_en),
    .dispatch_tag (dispatch_tag),
    .dispatch_idx (dispatch_idx),
    .rob_full     (rob_full),
    .retire_valid (retire_valid),
    .retire_tag   (retire_tag),
    .read_tag     (read_tag),
    .read_value   (read_value),
    .cdb          (cdb)
  );

  initial clock = 1'b0;
  always #5 clock = ~clock;

  // watchdog, counts cycles once reset is gone
  always @(posedge clock) begin
    if (!reset) begin
      cycle_count++;
      if (cycle_count >= cycle_limit) begin
        $display("timeout: run still busy after %0d cycles", cycle_limit);
        $display("STATUS: FAIL");
        $finish;
      end
    end
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;  // numerical recipes LCG
    return lcg_state;
  endfunction

  // walk from the entry after the branch up to the tail
  function automatic bit in_range(input int idx, input int rb, input int tail);
    int p;
    p = (rb + 1) % rob_depth;
    while (p != tail) begin
      if (p == idx) return 1'b1;
      p = (p + 1) % rob_depth;
    end
    return 1'b0;
  endfunction

  function automatic bit units_busy();
    bit busy;
    busy = 1'b0;
    for (int i = 0; i < num_fu; i++) begin
      busy |= (pend_rd[i] != pend_wr[i]) || mslot[i].taken;
    end
    return busy;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    check_count++;
    assert (exp_v === act_v) else begin
      error_count++;
      $display("Fail %s %s: expected %0h, actual %0h", cur_name, what, exp_v, act_v);
    end
  endtask

  task automatic add_row(input int r, input string name, input logic [3:0] n_disp,
                         input logic [num_fu*3-1:0] cnt, input logic [num_fu*3-1:0] off,
                         input logic [tag_width-1:0] tag_base, input logic rb_en,
                         input logic [2:0] rb_off, input logic [3:0] exp_bcast,
                         input logic [3:0] exp_retire);
    row_name[r] = name;
    rows[r] = '{n_disp: n_disp, cnt: cnt, off: off, tag_base: tag_base, rb_en: rb_en,
                rb_off: rb_off, exp_bcast: exp_bcast, exp_retire: exp_retire};
  endtask

  // units listed 3 down to 0 in each concatenation
  task automatic fill_table();
    add_row(0, "single_result", 4'd1, {3'd0, 3'd1, 3'd0, 3'd0}, {3'd0, 3'd0, 3'd0, 3'd0},
            5'd1, 1'b0, 3'd0, 4'd1, 4'd1);
    add_row(1, "simultaneous", 4'd4, {3'd1, 3'd1, 3'd1, 3'd1}, {3'd3, 3'd2, 3'd1, 3'd0},
            5'd2, 1'b0, 3'd0, 4'd4, 4'd4);
    add_row(2, "back_pressure", 4'd6, {3'd2, 3'd0, 3'd0, 3'd4}, {3'd4, 3'd0, 3'd0, 3'd0},
            5'd8, 1'b0, 3'd0, 4'd6, 4'd6);   // unit 0 keeps slot 0 busy
    add_row(3, "retire_order", 4'd4, {3'd1, 3'd1, 3'd1, 3'd1}, {3'd0, 3'd1, 3'd2, 3'd3},
            5'd16, 1'b0, 3'd0, 4'd4, 4'd4);  // youngest broadcast first
    add_row(4, "rollback_wrap", 4'd4, {3'd1, 3'd1, 3'd1, 3'd1}, {3'd2, 3'd3, 3'd0, 3'd1},
            5'd20, 1'b1, 3'd0, 4'd1, 4'd1);  // entries 7,0,1,2, branch at 7
    add_row(5, "rollback_mid", 4'd4, {3'd1, 3'd1, 3'd1, 3'd1}, {3'd1, 3'd3, 3'd0, 3'd2},
            5'd2, 1'b1, 3'd1, 4'd2, 4'd2);   // tags 4,5 keep their older values
  endtask

  task automatic drive_units();
    for (int i = 0; i < num_fu; i++) begin
      fu_done[i]   = pend_rd[i] != pend_wr[i];   // hold until handed over
      fu_result[i] = fu_done[i] ? pend[i][pend_rd[i]] : '0;
    end
  endtask

  // check one cycle at the falling edge, then move the model across the rising edge
  task automatic step_cycle();
    int                   win;
    int                   tail_now;
    bit                   exp_valid;
    bit                   retire_exp;
    logic [num_fu-1:0]    exp_ready;
    int                   q_idx [$];
    logic [tag_width-1:0] q_tag [$];
    @(negedge clock);
    win = -1;
    for (int i = num_fu - 1; i >= 0; i--) begin
      if (mslot[i].taken) win = i;              // lowest taken slot ends up here
    end
    exp_valid = (win >= 0) && !rollback.en;
    check_value("dispatch_idx", model_tail, dispatch_idx);
    check_value("rob_full", rq_idx.size() == rob_depth, rob_full);
    check_value("cdb.valid", exp_valid, cdb.valid);
    if (exp_valid && cdb.valid) begin
      check_value("cdb.tag", mslot[win].res.tag, cdb.tag);
      check_value("cdb.value", mslot[win].res.value, cdb.value);
      check_value("cdb.rob_idx", mslot[win].res.rob_idx, cdb.rob_idx);
    end
    for (int i = 0; i < num_fu; i++) begin
      exp_ready[i] = !mslot[i].taken || (exp_valid && win == i);
    end
    check_value("fu_ready", exp_ready, fu_ready);
    retire_exp = (rq_idx.size() != 0) && comp_done[rq_idx[0]];
    check_value("retire_valid", retire_exp, retire_valid);
    if (retire_exp && retire_valid) begin
      check_value("retire_tag", rq_tag[0], retire_tag);
      comp_done[rq_idx[0]] = 1'b0;
      void'(rq_idx.pop_front());
      void'(rq_tag.pop_front());
      retire_count++;
    end
    tail_now = model_tail;
    if (exp_valid) begin
      exp_regs[mslot[win].res.tag] = mslot[win].res.value;
      comp_done[mslot[win].res.rob_idx] = 1'b1;
      mslot[win].taken = 1'b0;
      bcast_count++;
    end
    if (rollback.en) begin
      for (int i = 0; i < num_fu; i++) begin
        if (mslot[i].taken && in_range(mslot[i].res.rob_idx, rollback.rob_idx, tail_now)) begin
          mslot[i].taken = 1'b0;                 // squashed, never broadcast
        end
      end
      for (int n = 0; n < rq_idx.size(); n++) begin
        if (!in_range(rq_idx[n], rollback.rob_idx, tail_now)) begin
          q_idx.push_back(rq_idx[n]);
          q_tag.push_back(rq_tag[n]);
        end
      end
      rq_idx = q_idx;
      rq_tag = q_tag;
      model_tail = (int'(rollback.rob_idx) + 1) % rob_depth;
    end else if (dispatch_en) begin
      rq_idx.push_back(model_tail);
      rq_tag.push_back(dispatch_tag);
      comp_done[model_tail] = 1'b0;
      model_tail = (model_tail + 1) % rob_depth;
    end
    for (int i = 0; i < num_fu; i++) begin
      if (pend_rd[i] != pend_wr[i] && exp_ready[i]) begin
        if (!(rollback.en && in_range(pend[i][pend_rd[i]].rob_idx, rollback.rob_idx,
                                      tail_now))) begin
          mslot[i] = '{taken: 1'b1, res: pend[i][pend_rd[i]]};
        end
        pend_rd[i]++;                              // handshake done either way
      end
    end
    @(posedge clock);
    #1;
    drive_units();
  endtask

  task automatic report_test(input int errors_before);
    if (error_count == errors_before) begin
      $display("test %-14s ok", cur_name);
    end else begin
      tests_failed++;
      $display("test %-14s failed, %0d errors", cur_name, error_count - errors_before);
    end
  endtask

  initial begin
    int base;
    int k;
    int cyc;
    int errors_before;
    int bcast_before;
    int retire_before;
    fill_table();
    reset        = 1'b1;
    fu_done      = '0;
    fu_result    = '0;
    rollback     = '0;
    dispatch_en  = 1'b0;
    dispatch_tag = '0;
    read_tag     = '0;
    model_tail   = 0;
    for (int i = 0; i < num_fu; i++) begin
      mslot[i]   = '0;
      pend_rd[i] = 0;
      pend_wr[i] = 0;
    end
    for (int i = 0; i < num_pregs; i++) exp_regs[i] = '0;
    for (int i = 0; i < rob_depth; i++) comp_done[i] = 1'b0;
    repeat (8) @(posedge clock);
    #1;
    reset = 1'b0;

    // idle outputs and a cleared register file
    cur_name = "reset_state";
    errors_before = error_count;
    for (int t = 0; t < num_pregs; t++) begin
      read_tag = tag_width'(t);
      @(negedge clock);
      check_value("read_value", '0, read_value);
      if (t == 0) begin
        check_value("fu_ready", {num_fu{1'b1}}, fu_ready);
        check_value("cdb.valid", 1'b0, cdb.valid);
        check_value("retire_valid", 1'b0, retire_valid);
        check_value("rob_full", 1'b0, rob_full);
        check_value("dispatch_idx", '0, dispatch_idx);
      end
      @(posedge clock);
      #1;
    end
    report_test(errors_before);

    for (int r = 0; r < num_rows; r++) begin
      cur_name      = row_name[r];
      errors_before = error_count;
      bcast_before  = bcast_count;
      retire_before = retire_count;
      base          = model_tail;
      for (int d = 0; d < rows[r].n_disp; d++) begin
        dispatch_en  = 1'b1;
        dispatch_tag = tag_width'(rows[r].tag_base + d);
        step_cycle();
      end
      dispatch_en = 1'b0;
      for (int i = 0; i < num_fu; i++) begin
        for (int j = 0; j < rows[r].cnt[i]; j++) begin
          k = rows[r].off[i] + j;
          pend[i][pend_wr[i]].tag     = tag_width'(rows[r].tag_base + k);
          pend[i][pend_wr[i]].value   = next_random();
          pend[i][pend_wr[i]].rob_idx = rob_idx_width'((base + k) % rob_depth);
          pend_wr[i]++;
        end
      end
      drive_units();
      cyc = 0;
      while (units_busy() || rq_idx.size() != 0) begin
        rollback.en      = rows[r].rb_en && (cyc == 1);  // slots all full then
        rollback.rob_idx = rob_idx_width'((base + rows[r].rb_off) % rob_depth);
        step_cycle();
        cyc++;
      end
      rollback = '0;
      for (int i = 0; i < num_fu; i++) begin
        pend_rd[i] = 0;
        pend_wr[i] = 0;
      end
      // register readback, squashed tags still hold older data
      for (int d = 0; d < rows[r].n_disp; d++) begin
        read_tag = tag_width'(rows[r].tag_base + d);
        @(negedge clock);
        check_value("read_value", exp_regs[read_tag], read_value);
        @(posedge clock);
        #1;
      end
      check_value("broadcasts", rows[r].exp_bcast, bcast_count - bcast_before);
      check_value("retirements", rows[r].exp_retire, retire_count - retire_before);
      report_test(errors_before);
    end

    $display("tests %0d, failed %0d, checks %0d, errors %0d", num_rows + 1, tests_failed,
             check_count, error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== src/complete_stage.sv ====
// complete stage top: completion buffer, phys reg file and ROB status on one CDB
`timescale 1ns/1ps

module complete_stage (
  input  logic                                       clock,
  input  logic                                       reset,
  // functional unit side
  input  logic [cdb_pkg::num_fu-1:0]                 fu_done,
  input  cdb_pkg::fu_result_t [cdb_pkg::num_fu-1:0]  fu_result,
  output logic [cdb_pkg::num_fu-1:0]                 fu_ready,
  // branch recovery
  input  cdb_pkg::rollback_t                         rollback,
  // dispatch side
  input  logic                                       dispatch_en,
  input  logic [cdb_pkg::tag_width-1:0]              dispatch_tag,
  output logic [cdb_pkg::rob_idx_width-1:0]          dispatch_idx,
  output logic                                       rob_full,
  // commit side
  output logic                                       retire_valid,
  output logic [cdb_pkg::tag_width-1:0]              retire_tag,
  // register read port
  input  logic [cdb_pkg::tag_width-1:0]              read_tag,
  output logic [cdb_pkg::data_width-1:0]             read_value,
  output cdb_pkg::cdb_t                              cdb
);
  import cdb_pkg::*;

  logic [rob_idx_width-1:0] rob_tail;   // squash range end

  complete_buffer u_complete_buffer (
    .clock     (clock),
    .reset     (reset),
    .fu_done   (fu_done),
    .fu_result (fu_result),
    .fu_ready  (fu_ready),
    .rollback  (rollback),
    .rob_tail  (rob_tail),
    .cdb       (cdb)
  );

  phys_reg_file u_phys_reg_file (
    .clock      (clock),
    .reset      (reset),
    .cdb        (cdb),
    .read_tag   (read_tag),
    .read_value (read_value)
  );

  rob_status u_rob_status (
    .clock        (clock),
    .reset        (reset),
    .dispatch_en  (dispatch_en),
    .dispatch_tag (dispatch_tag),
    .dispatch_idx (dispatch_idx),
    .rob_full     (rob_full),
    .cdb          (cdb),
    .rollback     (rollback),
    .rob_tail     (rob_tail),
    .retire_valid (retire_valid),
    .retire_tag   (retire_tag)
  );

endmodule

// ==== src/rob_status.sv ====
// ROB status ring with allocate, complete bits, in-order retire and rollback of the tail
`timescale 1ns/1ps

module rob_status (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic                                  dispatch_en,
  input  logic [cdb_pkg::tag_width-1:0]         dispatch_tag,
  output logic [cdb_pkg::rob_idx_width-1:0]     dispatch_idx,
  output logic                                  rob_full,
  input  cdb_pkg::cdb_t                         cdb,
  input  cdb_pkg::rollback_t                    rollback,
  output logic [cdb_pkg::rob_idx_width-1:0]     rob_tail,
  output logic                                  retire_valid,
  output logic [cdb_pkg::tag_width-1:0]         retire_tag
);
  import cdb_pkg::*;

  logic [tag_width-1:0]     dest_tag [rob_depth];  // stored at dispatch
  logic [rob_depth-1:0]     complete;
  logic [rob_idx_width-1:0] head;
  logic [rob_idx_width-1:0] tail;
  logic [rob_cnt_width-1:0] count;
  logic [rob_cnt_width-1:0] count_next;
  logic                     alloc;
  logic                     retire;
  logic [rob_idx_width-1:0] rb_dist;    // branch distance from head
  logic [rob_idx_width-1:0] cdb_dist;   // completing entry distance from head

  assign rob_full     = count == rob_cnt_width'(rob_depth);
  assign dispatch_idx = tail;
  assign rob_tail     = tail;
  assign alloc        = dispatch_en && !rob_full && !rollback.en;  // frontend flushed on rollback
  assign retire_valid = (count != '0) && complete[head];
  assign retire_tag   = dest_tag[head];
  assign retire       = retire_valid;   // commit always accepts
  assign rb_dist      = rollback.rob_idx - head;
  assign cdb_dist     = cdb.rob_idx - head;

  always_comb begin
    if (rollback.en) begin
      // keep head up to and including the branch
      count_next = rob_cnt_width'(rb_dist) + 1'b1 - rob_cnt_width'(retire);
    end else begin
      count_next = count + rob_cnt_width'(alloc) - rob_cnt_width'(retire);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head     <= '0;
      tail     <= '0;
      count    <= '0;
      complete <= '0;
    end else begin
      count <= count_next;
      if (retire) begin
        head           <= head + 1'b1;
        complete[head] <= 1'b0;
      end
      if (rollback.en) begin
        tail <= rollback.rob_idx + 1'b1;   // first entry after the branch
        for (int i = 0; i < rob_depth; i++) begin
          if (in_squash(rob_idx_width'(i), rollback.rob_idx, tail)) begin
            complete[i] <= 1'b0;           // dropped entries forget completion
          end
        end
      end else if (alloc) begin
        tail           <= tail + 1'b1;
        complete[tail] <= 1'b0;
      end
      if (cdb.valid) begin
        complete[cdb.rob_idx] <= 1'b1;    // bus never valid in a rollback cycle
      end
    end
  end

  always_ff @(posedge clock) begin
    if (alloc) begin
      dest_tag[tail] <= dispatch_tag;
    end
  end

  // completion only for live entries
  a_complete_live: assert property (@(posedge clock) disable iff (reset)
    cdb.valid |-> rob_cnt_width'(cdb_dist) < count);

  a_no_dispatch_full: assert property (@(posedge clock) disable iff (reset)
    dispatch_en |-> !rob_full);

endmodule

// ==== src/phys_reg_file.sv ====
// physical register file, written from the CDB, one combinational read port
`timescale 1ns/1ps

module phys_reg_file (
  input  logic                              clock,
  input  logic                              reset,
  input  cdb_pkg::cdb_t                     cdb,
  input  logic [cdb_pkg::tag_width-1:0]     read_tag,
  output logic [cdb_pkg::data_width-1:0]    read_value
);
  import cdb_pkg::*;

  logic [data_width-1:0] regs [num_pregs];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_pregs; i++) begin
        regs[i] <= '0;
      end
    end else if (cdb.valid) begin
      regs[cdb.tag] <= cdb.value;     // one write per cycle from the bus
    end
  end

  assign read_value = regs[read_tag];  // no bypass so a write shows next cycle

  // broadcast payload must be clean whenever it is written
  a_clean_write: assert property (@(posedge clock) disable iff (reset)
    cdb.valid |-> !$isunknown({cdb.tag, cdb.value}));

endmodule

// ==== src/complete_buffer.sv ====
// completion buffer with one result slot per functional unit, CDB pick and rollback squash
`timescale 1ns/1ps

module complete_buffer (
  input  logic                                       clock,
  input  logic                                       reset,
  input  logic [cdb_pkg::num_fu-1:0]                 fu_done,
  input  cdb_pkg::fu_result_t [cdb_pkg::num_fu-1:0]  fu_result,
  output logic [cdb_pkg::num_fu-1:0]                 fu_ready,
  input  cdb_pkg::rollback_t                         rollback,
  input  logic [cdb_pkg::rob_idx_width-1:0]          rob_tail,
  output cdb_pkg::cdb_t                              cdb
);
  import cdb_pkg::*;

  ct_entry_t [num_fu-1:0] slot;       // registered slots
  logic [num_fu-1:0]      occupied;
  logic [num_fu-1:0]      grant;      // one-hot slot on the bus this cycle
  logic [num_fu-1:0]      squash;     // held result killed by rollback
  logic [num_fu-1:0]      drop_in;    // incoming result killed by rollback
  logic [num_fu-1:0]      take;       // slot loads from its unit
  fu_result_t             sel;        // payload of the winning slot

  always_comb begin
    for (int i = 0; i < num_fu; i++) begin
      occupied[i] = slot[i].taken;
    end
  end

  // lowest occupied slot wins and nobody wins during rollback
  always_comb begin
    logic found;
    found = 1'b0;
    grant = '0;
    sel   = '0;
    for (int i = 0; i < num_fu; i++) begin
      if (occupied[i] && !found) begin
        found    = 1'b1;
        sel      = slot[i].res;
        grant[i] = ~rollback.en;      // slot only drains on a real broadcast
      end
    end
  end

  assign cdb = '{valid:   (|occupied) & ~rollback.en,
                 tag:     sel.tag,
                 value:   sel.value,
                 rob_idx: sel.rob_idx};

  // per-slot handshake and squash decode
  always_comb begin
    for (int i = 0; i < num_fu; i++) begin
      squash[i]   = rollback.en && slot[i].taken &&
                    in_squash(slot[i].res.rob_idx, rollback.rob_idx, rob_tail);
      drop_in[i]  = rollback.en &&
                    in_squash(fu_result[i].rob_idx, rollback.rob_idx, rob_tail);
      fu_ready[i] = !slot[i].taken || grant[i];  // empty or draining now
      take[i]     = fu_done[i] && fu_ready[i] && !drop_in[i];
    end
  end

  // wrong-path results complete the handshake and are dropped here
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_fu; i++) begin
        slot[i].taken <= 1'b0;        // slot empty
      end
    end else begin
      for (int i = 0; i < num_fu; i++) begin
        if (take[i]) begin
          slot[i] <= '{taken: 1'b1, res: fu_result[i]};  // refill can share an edge with a drain
        end else if (grant[i] || squash[i]) begin
          slot[i].taken <= 1'b0;
        end
      end
    end
  end

  // a held result that is not broadcast or squashed stays put unchanged
  for (genvar g = 0; g < num_fu; g++) begin : g_slot_chk
    a_hold_slot: assert property (@(posedge clock) disable iff (reset)
      slot[g].taken && !grant[g] && !squash[g]
      |=> slot[g].taken && (slot[g].res == $past(slot[g].res)));
  end

  // nothing goes out on the bus in a rollback cycle so unsquashed slots stay full
  a_quiet_rollback: assert property (@(posedge clock) disable iff (reset)
    rollback.en |=> (($past(occupied) & ~$past(squash) & ~occupied) == '0));

  // every slot left after a rollback is outside the squash range
  a_squash_done: assert property (@(posedge clock) disable iff (reset)
    rollback.en |=> (($past(squash) & occupied) == '0));

endmodule

// ==== src/cdb_pkg.sv ====
// widths, counts, packed result/slot/bus/rollback structs and the squash range check
package cdb_pkg;

  localparam int num_fu        = 4;   // functional units, one completion slot each
  localparam int tag_width     = 5;
  localparam int num_pregs     = 32;  // 2**tag_width
  localparam int data_width    = 32;
  localparam int rob_depth     = 8;
  localparam int rob_idx_width = 3;
  localparam int rob_cnt_width = 4;   // holds 0..rob_depth

  typedef struct packed {
    logic [tag_width-1:0]     tag;      // destination phys reg
    logic [data_width-1:0]    value;
    logic [rob_idx_width-1:0] rob_idx;
  } fu_result_t;                        // 40 bits

  typedef struct packed {
    logic       taken;                  // slot holds a result
    fu_result_t res;
  } ct_entry_t;                         // 41 bits

  typedef struct packed {
    logic                     valid;
    logic [tag_width-1:0]     tag;
    logic [data_width-1:0]    value;
    logic [rob_idx_width-1:0] rob_idx;
  } cdb_t;                              // 41 bits

  typedef struct packed {
    logic                     en;
    logic [rob_idx_width-1:0] rob_idx;  // mispredicted branch
  } rollback_t;                         // 4 bits

  // true when idx lies strictly after rb_idx and strictly before tail, circularly
  function automatic logic in_squash(input logic [rob_idx_width-1:0] idx,
                                     input logic [rob_idx_width-1:0] rb_idx,
                                     input logic [rob_idx_width-1:0] tail);
    logic [rob_idx_width-1:0] d_idx;
    logic [rob_idx_width:0]   d_tail;
    d_idx  = idx - rb_idx;                        // distance past the branch
    d_tail = {1'b0, rob_idx_width'(tail - rb_idx)};
    if (d_tail == '0) begin
      d_tail = (rob_idx_width + 1)'(rob_depth);   // full ring, all younger entries
    end
    return (d_idx != '0) && ({1'b0, d_idx} < d_tail);
  endfunction

endpackage
